// ==== design/exceptionPkg.sv ====
package exceptionPkg;

  // Instruction exception flags caught in E
  // Bit order is SWI, prefetch abort, undefined instruction
  typedef logic [2:0] excFlags;

  // Bit positions inside excFlags
  localparam int flagSwi      = 2;
  localparam int flagPrefetch = 1;
  localparam int flagUndef    = 0;

  // Flush controls ordered D, E, M, W from msb to lsb
  typedef logic [3:0] flushGroup;

  // No stage flushed
  localparam flushGroup flushNone  = 4'b0000;
  // First cycle of a data abort
  localparam flushGroup flushAll   = 4'b1111;
  // Instruction exception seen in E
  localparam flushGroup flushDEM   = 4'b1110;
  // Second cycle of a data abort
  localparam flushGroup flushDMW   = 4'b1011;
  // Hold the bubble behind the faulting or last instruction
  localparam flushGroup flushOnlyE = 4'b0100;
  // Drop the fetched instruction while the vector is taken
  localparam flushGroup flushOnlyD = 4'b1000;

  // Handler FSM states
  // Interrupt states track the last good instruction down the pipe
  typedef enum logic [2:0] {
    ready,
    dataAbort2,
    intE,
    intM,
    intW,
    exceptionM,
    exceptionW
  } handlerState;

endpackage

// ==== design/vectorPkg.sv ====
package vectorPkg;

  // Fetch and decode addresses
  typedef logic [31:0] pcAddr;

  // Exception vector number, fetch address is index times four
  typedef logic [2:0] vectorIndex;

  // Link offset select handed to the PC mux
  typedef logic [1:0] linkSel;

  // Normal flow saves PC of D plus 8
  localparam linkSel linkSelNormal = 2'b00;
  // Aborts and instruction exceptions save PC of D as is
  localparam linkSel linkSelPlus0  = 2'b01;
  // Interrupts save PC of D plus 4
  localparam linkSel linkSelPlus4  = 2'b10;

  // Offsets added to PC of D for each select
  localparam pcAddr linkOffset0 = 32'd0;
  localparam pcAddr linkOffset4 = 32'd4;
  localparam pcAddr linkOffset8 = 32'd8;

  // Vector table
  // Index 5 is the unused address exception slot
  localparam vectorIndex vecReset     = 3'd0;
  localparam vectorIndex vecUndef     = 3'd1;
  localparam vectorIndex vecSwi       = 3'd2;
  localparam vectorIndex vecPrefetch  = 3'd3;
  localparam vectorIndex vecDataAbort = 3'd4;
  localparam vectorIndex vecIrq       = 3'd6;
  localparam vectorIndex vecFiq       = 3'd7;

endpackage

// ==== design/exceptionPipeRegs.sv ====
module exceptionPipeRegs import exceptionPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    undefinedE,
  input  logic    swiE,
  input  logic    prefetchAbortE,
  input  logic    stallE,
  input  logic    stallM,
  input  logic    stallW,
  input  logic    clearM,
  input  logic    clearW,
  input  logic    irqEnabled,
  input  logic    fiqEnabled,
  input  logic    pcUpdateW,
  output excFlags flagsW,
  output logic    irqEnSync,
  output logic    fiqEnSync,
  output logic    unstallD
);

  excFlags flagsE;
  excFlags flagsM;

  // Pack the E stage flags
  always_comb begin
    flagsE               = '0;
    flagsE[flagSwi]      = swiE;
    flagsE[flagPrefetch] = prefetchAbortE;
    flagsE[flagUndef]    = undefinedE;
  end

  // E to M
  // Cleared when the FSM is busy with an earlier event
  always_ff @(posedge clk) begin
    if (reset) begin
      flagsM <= '0;
    end else if (!stallM) begin
      if (clearM)
        flagsM <= '0;
      else
        flagsM <= flagsE;
    end
  end

  // M to W, only the exception that reached exceptionM survives
  always_ff @(posedge clk) begin
    if (reset) begin
      flagsW <= '0;
    end else if (!stallW) begin
      if (clearW)
        flagsW <= '0;
      else
        flagsW <= flagsM;
    end
  end

  // CPSR enables change on the falling edge, move them to the rising edge
  always_ff @(posedge clk) begin
    if (reset) begin
      irqEnSync <= 1'b0;
      fiqEnSync <= 1'b0;
    end else begin
      irqEnSync <= irqEnabled;
      fiqEnSync <= fiqEnabled;
    end
  end

  // Remember a PC write in W so a branch target can enter D during intM
  always_ff @(posedge clk) begin
    if (reset)
      unstallD <= 1'b0;
    else if (!stallE)
      unstallD <= pcUpdateW;
  end

endmodule

// ==== design/exceptionHandler.sv ====
module exceptionHandler import exceptionPkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic undefinedE,
  input  logic swiE,
  input  logic prefetchAbortE,
  input  logic dataAbort,
  input  logic irq,
  input  logic fiq,
  input  logic irqEnSync,
  input  logic fiqEnSync,
  input  logic stallD,
  input  logic stallE,
  input  logic stallM,
  input  logic stallW,
  input  logic pcWrPendingF,
  input  logic unstallD,
  output logic flushD,
  output logic flushE,
  output logic flushM,
  output logic flushW,
  output logic exceptionStallD,
  output logic interrupting,
  output logic resetMicrop,
  output logic dataAbortCycle2,
  output logic irqAssert,
  output logic fiqAssert,
  output logic clearM,
  output logic clearW
);

  handlerState state;
  handlerState nextState;
  flushGroup   flushes;
  logic        instrException;
  logic        interruptPending;

  // Any exception raised by the instruction now in E
  assign instrException = undefinedE | swiE | prefetchAbortE;

  // Enabled request, an instruction exception in E takes precedence
  assign interruptPending = ((fiq & fiqEnSync) | (irq & irqEnSync)) & ~instrException;

  always_ff @(posedge clk) begin
    if (reset)
      state <= ready;
    else
      state <= nextState;
  end

  // Next state and flush controls
  always_comb begin
    flushes   = flushNone;
    nextState = state;
    case (state)
      ready: begin
        if (dataAbort) begin
          // Caught in M, kill everything younger and the result in W
          flushes   = flushAll;
          nextState = dataAbort2;
        end else if (instrException) begin
          // Caught in E
          // CPSR save waits until the exception reaches W
          flushes = flushDEM;
          if (!stallM)
            nextState = exceptionM;
        end else if (interruptPending) begin
          // Let the last instruction leave D first
          if (!stallD)
            nextState = intE;
        end
      end

      // Second data abort cycle, PC is saved here
      dataAbort2: begin
        flushes = flushDMW;
        if (!stallE)
          nextState = ready;
      end

      // Exception has moved to M
      exceptionM: begin
        flushes = flushOnlyE;
        if (!stallW)
          nextState = exceptionW;
      end

      // Exception in W, vector and link are taken now
      exceptionW: begin
        flushes = flushOnlyD;
        if (!stallE)
          nextState = ready;
      end

      // Last good instruction in E
      // PC writes hold the whole pipe until W so wait them out
      intE: begin
        flushes = flushOnlyE;
        if (!interruptPending)
          nextState = ready;
        else if (!(stallE | pcWrPendingF))
          nextState = intM;
      end

      // Last good instruction in M
      intM: begin
        flushes = flushOnlyE;
        if (!interruptPending)
          nextState = ready;
        else if (!stallM)
          nextState = intW;
      end

      // Last good instruction in W, assert the interrupt
      intW: begin
        flushes = flushOnlyD;
        if (!interruptPending || !stallW)
          nextState = ready;
      end

      default: begin
        flushes   = flushNone;
        nextState = ready;
      end
    endcase
  end

  assign {flushD, flushE, flushM, flushW} = flushes;

  // Something other than normal flow is in progress
  assign interrupting = (state != ready) | instrException;

  assign dataAbortCycle2 = (state == dataAbort2);

  // FIQ wins over IRQ
  assign fiqAssert = (state == intW) & fiq & fiqEnSync;
  assign irqAssert = (state == intW) & irq & irqEnSync & ~fiqAssert;

  // Hold D so its PC survives for the link
  // A pending PC write in intM lets the branch target into D
  assign exceptionStallD = (state == intE) |
                           ((state == intM) & ~unstallD) |
                           (state == exceptionM) |
                           ((state == ready) & (dataAbort | instrException));

  // A data abort also cancels the running micro-op sequence
  assign resetMicrop = dataAbort;

  // Flag pipe clears, M keeps only what enters from ready
  assign clearM = (state != ready);
  assign clearW = (state != exceptionM);

endmodule

// ==== design/exceptionVector.sv ====
module exceptionVector import exceptionPkg::*, vectorPkg::*; (
  input  logic       reset,
  input  excFlags    flagsW,
  input  logic       dataAbortCycle2,
  input  logic       irqAssert,
  input  logic       fiqAssert,
  input  pcAddr      pcD,
  output vectorIndex vectorPc,
  output logic       savePc,
  output linkSel     pcInSel,
  output pcAddr      linkAddr
);

  logic  swiW;
  logic  prefetchW;
  logic  undefW;
  logic  instrExcW;
  pcAddr linkOffset;

  assign swiW      = flagsW[flagSwi];
  assign prefetchW = flagsW[flagPrefetch];
  assign undefW    = flagsW[flagUndef];
  assign instrExcW = swiW | prefetchW | undefW;

  // Any of the seven sources redirects fetch
  assign savePc = reset | dataAbortCycle2 | fiqAssert | irqAssert | instrExcW;

  // Highest priority source picks the vector
  always_comb begin
    if (reset)
      vectorPc = vecReset;
    else if (dataAbortCycle2)
      vectorPc = vecDataAbort;
    else if (fiqAssert)
      vectorPc = vecFiq;
    else if (irqAssert)
      vectorPc = vecIrq;
    else if (prefetchW)
      vectorPc = vecPrefetch;
    else if (undefW)
      vectorPc = vecUndef;
    else if (swiW)
      vectorPc = vecSwi;
    else
      vectorPc = vecReset;
  end

  // Link offset select
  // Interrupts return past the instruction in D, faults retry it
  always_comb begin
    if (irqAssert | fiqAssert)
      pcInSel = linkSelPlus4;
    else if (instrExcW | dataAbortCycle2)
      pcInSel = linkSelPlus0;
    else
      pcInSel = linkSelNormal;
  end

  always_comb begin
    case (pcInSel)
      linkSelPlus4: linkOffset = linkOffset4;
      linkSelPlus0: linkOffset = linkOffset0;
      default:      linkOffset = linkOffset8;
    endcase
  end

  // Address saved into r14 of the exception mode
  assign linkAddr = pcD + linkOffset;

endmodule

// ==== design/exceptionUnit.sv ====
module exceptionUnit import exceptionPkg::*, vectorPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       undefinedE,
  input  logic       swiE,
  input  logic       prefetchAbortE,
  input  logic       dataAbort,
  input  logic       irq,
  input  logic       fiq,
  input  logic       irqEnabled,
  input  logic       fiqEnabled,
  input  logic       stallD,
  input  logic       stallE,
  input  logic       stallM,
  input  logic       stallW,
  input  logic       pcWrPendingF,
  input  logic       pcUpdateW,
  input  pcAddr      pcD,
  output logic       flushD,
  output logic       flushE,
  output logic       flushM,
  output logic       flushW,
  output logic       exceptionStallD,
  output logic       interrupting,
  output logic       resetMicrop,
  output logic       savePc,
  output vectorIndex vectorPc,
  output pcAddr      linkAddr,
  output linkSel     pcInSel,
  output logic       irqAssert,
  output logic       fiqAssert,
  output logic       dataAbortCycle2,
  output excFlags    flagsW
);

  // Between the flag pipe and the FSM
  logic irqEnSync;
  logic fiqEnSync;
  logic unstallD;
  logic clearM;
  logic clearW;

  // E flags down to W, synced enables and PC write latch
  exceptionPipeRegs pipeRegs (.*);

  // Sequencing of flushes, stalls and interrupt entry
  exceptionHandler handler (.*);

  // Vector index and link address
  exceptionVector vector (.*);

endmodule

// ==== test/exceptionUnitCases.svh ====
// Stimulus and expected outputs, one row per clock cycle
// Row columns are events, enables, stalls, flushes, controls, vector, link select
// Events are reset undefinedE swiE prefetchAbortE dataAbort irq fiq
// Enables are irqEnabled fiqEnabled
// Stalls are stallD stallE stallM stallW
// Flushes are D E M W
// Controls are exceptionStallD resetMicrop savePc irqAssert fiqAssert
// then interrupting dataAbortCycle2 and flagsW as SWI, prefetch, undefined
// Trailing comment names the handler state during the row
localparam int numRows = 36;

caseRow cases [numRows] = '{
  '{7'b1000000, 2'b00, 4'b0000, 4'b0000, 10'b0010000000, vecReset, linkSelNormal}, // ready, reset
  '{7'b1000000, 2'b00, 4'b0000, 4'b0000, 10'b0010000000, vecReset, linkSelNormal}, // ready, reset
  '{7'b1000000, 2'b00, 4'b0000, 4'b0000, 10'b0010000000, vecReset, linkSelNormal}, // ready, reset
  '{7'b0100000, 2'b00, 4'b0000, 4'b1110, 10'b1000010000, vecReset, linkSelNormal}, // ready, undef
  '{7'b0000000, 2'b00, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // exceptionM
  '{7'b0000000, 2'b00, 4'b0000, 4'b1000, 10'b0010010001, vecUndef, linkSelPlus0},  // exceptionW
  '{7'b0010000, 2'b00, 4'b0000, 4'b1110, 10'b1000010000, vecReset, linkSelNormal}, // ready, SWI
  '{7'b0000000, 2'b00, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // exceptionM
  '{7'b0000000, 2'b00, 4'b0000, 4'b1000, 10'b0010010100, vecSwi, linkSelPlus0},    // exceptionW
  '{7'b0001000, 2'b00, 4'b0000, 4'b1110, 10'b1000010000, vecReset, linkSelNormal}, // ready, prefetch
  '{7'b0000000, 2'b00, 4'b1111, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // exceptionM held
  '{7'b0000000, 2'b00, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // exceptionM
  '{7'b0000000, 2'b00, 4'b0000, 4'b1000, 10'b0010010010, vecPrefetch, linkSelPlus0}, // exceptionW
  '{7'b0000100, 2'b00, 4'b0000, 4'b1111, 10'b1100000000, vecReset, linkSelNormal}, // ready, abort
  '{7'b0000000, 2'b00, 4'b0100, 4'b1011, 10'b0010011000, vecDataAbort, linkSelPlus0}, // dataAbort2
  '{7'b0000000, 2'b00, 4'b0000, 4'b1011, 10'b0010011000, vecDataAbort, linkSelPlus0}, // dataAbort2
  '{7'b0000000, 2'b10, 4'b0000, 4'b0000, 10'b0000000000, vecReset, linkSelNormal}, // ready, IRQ on
  '{7'b0000010, 2'b10, 4'b0000, 4'b0000, 10'b0000000000, vecReset, linkSelNormal}, // ready, IRQ
  '{7'b0000010, 2'b10, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // intE
  '{7'b0000010, 2'b10, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // intM
  '{7'b0000010, 2'b10, 4'b0000, 4'b1000, 10'b0011010000, vecIrq, linkSelPlus4},    // intW
  '{7'b0000000, 2'b11, 4'b0000, 4'b0000, 10'b0000000000, vecReset, linkSelNormal}, // ready, FIQ on
  '{7'b0000011, 2'b11, 4'b0000, 4'b0000, 10'b0000000000, vecReset, linkSelNormal}, // ready, both
  '{7'b0000011, 2'b11, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // intE
  '{7'b0000011, 2'b11, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // intM
  '{7'b0000011, 2'b11, 4'b0000, 4'b1000, 10'b0010110000, vecFiq, linkSelPlus4},    // intW
  '{7'b0000010, 2'b11, 4'b0000, 4'b0000, 10'b0000000000, vecReset, linkSelNormal}, // ready, IRQ
  '{7'b0000010, 2'b11, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // intE
  '{7'b0000000, 2'b11, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // intM, dropped
  '{7'b0000000, 2'b00, 4'b0000, 4'b0000, 10'b0000000000, vecReset, linkSelNormal}, // ready, masks
  '{7'b0000010, 2'b00, 4'b0000, 4'b0000, 10'b0000000000, vecReset, linkSelNormal}, // ready, masked
  '{7'b0000010, 2'b10, 4'b0000, 4'b0000, 10'b0000000000, vecReset, linkSelNormal}, // ready, syncing
  '{7'b0100010, 2'b10, 4'b0000, 4'b1110, 10'b1000010000, vecReset, linkSelNormal}, // ready, undef+IRQ
  '{7'b0000010, 2'b10, 4'b0000, 4'b0100, 10'b1000010000, vecReset, linkSelNormal}, // exceptionM
  '{7'b0000000, 2'b00, 4'b0000, 4'b1000, 10'b0010010001, vecUndef, linkSelPlus0},  // exceptionW
  '{7'b0000000, 2'b00, 4'b0000, 4'b0000, 10'b0000000000, vecReset, linkSelNormal}  // ready
};

// ==== test/exceptionUnitTb.sv ====
module exceptionUnitTb import exceptionPkg::*, vectorPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clkPeriod = 8;

  // One clock cycle of stimulus with its expected outputs
  typedef struct packed {
    logic [6:0] events;
    logic [1:0] enables;
    logic [3:0] stalls;
    flushGroup  flushes;
    logic [9:0] controls;
    vectorIndex vecIndex;
    linkSel     linkCode;
  } caseRow;

  `include "exceptionUnitCases.svh"

  // DUT inputs
  logic  clk;
  logic  reset;
  logic  undefinedE, swiE, prefetchAbortE, dataAbort;
  logic  irq, fiq, irqEnabled, fiqEnabled;
  logic  stallD, stallE, stallM, stallW;
  logic  pcWrPendingF, pcUpdateW;
  pcAddr pcD;

  // DUT outputs
  logic       flushD, flushE, flushM, flushW;
  logic       exceptionStallD, interrupting, resetMicrop, savePc;
  vectorIndex vectorPc;
  pcAddr      linkAddr;
  linkSel     pcInSel;
  logic       irqAssert, fiqAssert, dataAbortCycle2;
  excFlags    flagsW;

  int rowIndex;
  int checks;
  int errors;

  exceptionUnit DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Watchdog sized from the table length plus a margin
  initial begin
    #(numRows * clkPeriod + 200);
    $display("Timeout, the table did not finish within %0d ns", numRows * clkPeriod + 200);
    $display("Simulation FAILED");
    $finish;
  end

  // Pseudo random decode addresses
  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Link saved to r14 for a given select
  // Interrupts return past D, faults retry D, normal flow sits at D plus 8
  function automatic pcAddr expectedLink(input pcAddr pc, input linkSel code);
    pcAddr offset;
    if (code == linkSelPlus4)
      offset = 32'd4;
    else if (code == linkSelPlus0)
      offset = 32'd0;
    else
      offset = 32'd8;
    return pc + offset;
  endfunction

  // Compare one output with its expected value
  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checks++;
    assert (actual === expected)
    else begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h (row %0d)",
               name, actual, expected, rowIndex);
    end
  endtask

  initial begin
    caseRow row;
    pcAddr  seed;
    pcAddr  pcDriven;
    checks = 0;
    errors = 0;
    seed   = 32'h573b_e2d6;
    // Reset from time zero, pipeline idle
    reset          = 1'b1;
    undefinedE     = 1'b0;
    swiE           = 1'b0;
    prefetchAbortE = 1'b0;
    dataAbort      = 1'b0;
    irq            = 1'b0;
    fiq            = 1'b0;
    irqEnabled     = 1'b0;
    fiqEnabled     = 1'b0;
    stallD         = 1'b0;
    stallE         = 1'b0;
    stallM         = 1'b0;
    stallW         = 1'b0;
    pcWrPendingF   = 1'b0;
    pcUpdateW      = 1'b0;
    pcD            = '0;
    for (int i = 0; i < numRows; i++) begin
      row      = cases[i];
      seed     = xorshift32(seed);
      // Word aligned decode address
      pcDriven = seed & 32'hffff_fffc;
      @(posedge clk);
      rowIndex = i;
      {reset, undefinedE, swiE, prefetchAbortE, dataAbort, irq, fiq} <= row.events;
      {irqEnabled, fiqEnabled} <= row.enables;
      {stallD, stallE, stallM, stallW} <= row.stalls;
      pcD <= pcDriven;
      // Sample just ahead of the next edge
      #(clkPeriod - 1);
      checkValue("flushes", 32'({flushD, flushE, flushM, flushW}), 32'(row.flushes));
      checkValue("exceptionStallD", 32'(exceptionStallD), 32'(row.controls[9]));
      checkValue("resetMicrop", 32'(resetMicrop), 32'(row.controls[8]));
      checkValue("savePc", 32'(savePc), 32'(row.controls[7]));
      checkValue("irqAssert", 32'(irqAssert), 32'(row.controls[6]));
      checkValue("fiqAssert", 32'(fiqAssert), 32'(row.controls[5]));
      checkValue("interrupting", 32'(interrupting), 32'(row.controls[4]));
      checkValue("dataAbortCycle2", 32'(dataAbortCycle2), 32'(row.controls[3]));
      checkValue("flagsW", 32'(flagsW), 32'(row.controls[2:0]));
      checkValue("vectorPc", 32'(vectorPc), 32'(row.vecIndex));
      checkValue("pcInSel", 32'(pcInSel), 32'(row.linkCode));
      checkValue("linkAddr", linkAddr, expectedLink(pcDriven, row.linkCode));
    end
    $display("Rows: %0d, checks: %0d, errors: %0d", numRows, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== exceptionUnit.f ====
+incdir+test
design/exceptionPkg.sv
design/vectorPkg.sv
design/exceptionPipeRegs.sv
design/exceptionHandler.sv
design/exceptionVector.sv
design/exceptionUnit.sv
test/exceptionUnitTb.sv

// ==== Makefile ====
# Verilator build and run of the exception unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module exceptionUnitTb -Mdir obj_dir -f exceptionUnit.f
	./obj_dir/VexceptionUnitTb | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
